// File: source/match_pkg.sv
package match_pkg;

    // Bus and storage widths
    localparam int HOST_WORD_W = 32;
    localparam int RAM_WORD_W  = 64;
    localparam int RAM_LANES   = 8;

    // Result field widths
    localparam int IDX_W = 16;
    localparam int SAD_W = 16;

    // Host write command, one byte into one lane
    typedef struct packed {
        logic [17:0] pad_hi;
        logic [2:0]  lane;     // Byte lane of the RAM word
        logic [2:0]  pad_lo;
        logic [7:0]  data;     // Byte to store
    } wr_cmd_t;

    // Host read command, picks which half of the patch comes back
    typedef struct packed {
        logic [19:0] pad_hi;
        logic        half;
        logic [10:0] pad_lo;
    } rd_cmd_t;

    // Same host word seen as a write or as a read request
    typedef union packed {
        wr_cmd_t wr_cmd;
        rd_cmd_t rd_cmd;
    } host_cmd_u;

    typedef struct packed {
        logic [IDX_W-1:0] best_idx;
        logic [SAD_W-1:0] best_sad;
    } match_result_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DRAIN,
        DONE
    } scan_state_e;

endpackage

// File: source/patch_ram.sv
`timescale 1ns/1ps

module patch_ram #(
    parameter int ADDR_WIDTH = 9,
    parameter int DEPTH      = 512
) (
    input  logic                                clk,
    // Port 0, read or byte-masked write
    input  logic                                csb0_i,
    input  logic                                web0_i,
    input  logic [match_pkg::RAM_LANES-1:0]     wmask0_i,
    input  logic [ADDR_WIDTH-1:0]               addr0_i,
    input  logic [match_pkg::RAM_WORD_W-1:0]    din0_i,
    output logic [match_pkg::RAM_WORD_W-1:0]    dout0_o,
    // Port 1, read only
    input  logic                                csb1_i,
    input  logic [ADDR_WIDTH-1:0]               addr1_i,
    output logic [match_pkg::RAM_WORD_W-1:0]    dout1_o
);

    localparam int WORD_W = match_pkg::RAM_WORD_W;
    localparam int LANES  = match_pkg::RAM_LANES;
    localparam int LANE_W = WORD_W / LANES;

    logic [WORD_W-1:0] mem [DEPTH];

    // Port 0 writes enabled lanes only, otherwise reads
    always_ff @(posedge clk) begin
        if (!csb0_i) begin
            if (!web0_i) begin
                for (int i = 0; i < LANES; i++) begin
                    if (wmask0_i[i]) begin
                        mem[addr0_i][i*LANE_W +: LANE_W] <= din0_i[i*LANE_W +: LANE_W];
                    end
                end
            end else begin
                dout0_o <= mem[addr0_i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!csb1_i) begin
            dout1_o <= mem[addr1_i];   // Registered read, data next cycle
        end
    end

endmodule

// File: source/query_patch_mem.sv
`timescale 1ns/1ps

module query_patch_mem #(
    parameter int DATA_WIDTH = 11,
    parameter int PATCH_SIZE = 5,
    parameter int ADDR_WIDTH = 9,
    parameter int DEPTH      = 512,
    parameter int HOST_BASE  = 557
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    // Host side
    input  logic                                 host_we_i,
    input  logic                                 host_re_i,
    input  logic [31:0]                          host_addr_i,
    input  match_pkg::host_cmd_u                 host_cmd_i,
    output logic [match_pkg::HOST_WORD_W-1:0]    host_rdata_o,
    // Engine side
    input  logic                                 eng_re_i,
    input  logic [ADDR_WIDTH-1:0]                eng_addr_i,
    output logic [DATA_WIDTH*PATCH_SIZE-1:0]     eng_patch_o
);

    localparam int PATCH_W = DATA_WIDTH * PATCH_SIZE;
    localparam int WORD_W  = match_pkg::RAM_WORD_W;
    localparam int LANES   = match_pkg::RAM_LANES;
    localparam int HOST_W  = match_pkg::HOST_WORD_W;

    logic [ADDR_WIDTH-1:0] host_entry;
    logic [LANES-1:0]      wr_mask;
    logic [WORD_W-1:0]     wr_word;
    logic [WORD_W-1:0]     rd0_word;
    logic [WORD_W-1:0]     rd1_word;
    logic [WORD_W-1:0]     rd_patch;
    logic                  half_q;
    logic                  rd_valid_q;

    assign host_entry = ADDR_WIDTH'(host_addr_i - HOST_BASE);

    // One-hot lane mask, byte moved into its lane
    assign wr_mask = LANES'(1) << host_cmd_i.wr_cmd.lane;
    assign wr_word = WORD_W'(host_cmd_i.wr_cmd.data) << (8 * host_cmd_i.wr_cmd.lane);

    // Half select travels with the read so the returned data matches its request
    always_ff @(posedge clk) begin
        if (rst_i) begin
            half_q     <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= host_re_i & ~host_we_i;
            if (host_re_i) begin
                half_q <= host_cmd_i.rd_cmd.half;
            end
        end
    end

    // Bits above the patch may hold stray lane writes, clear them
    always_comb begin
        rd_patch = '0;
        rd_patch[PATCH_W-1:0] = rd0_word[PATCH_W-1:0];
    end

    always_comb begin
        if (!rd_valid_q) begin
            host_rdata_o = '0;
        end else if (half_q) begin
            host_rdata_o = rd_patch[2*HOST_W-1:HOST_W];   // Upper patch bits
        end else begin
            host_rdata_o = rd_patch[HOST_W-1:0];
        end
    end

    assign eng_patch_o = rd1_word[PATCH_W-1:0];

    patch_ram #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH)
    ) u_patch_ram (
        .clk        (clk),
        .csb0_i     (~(host_we_i | host_re_i)),
        .web0_i     (~host_we_i),
        .wmask0_i   (wr_mask),
        .addr0_i    (host_entry),
        .din0_i     (wr_word),
        .dout0_o    (rd0_word),
        .csb1_i     (~eng_re_i),
        .addr1_i    (eng_addr_i),
        .dout1_o    (rd1_word)
    );

endmodule

// File: source/scan_counter.sv
`timescale 1ns/1ps

module scan_counter #(
    parameter int ADDR_WIDTH = 9
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  clear_i,
    input  logic                  en_i,
    input  logic [ADDR_WIDTH:0]   num_i,
    output logic [ADDR_WIDTH-1:0] addr_o,
    output logic                  last_o
);

    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH:0]   count_q;   // Entries in this scan

    always_ff @(posedge clk) begin
        if (rst_i) begin
            addr_q  <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            addr_q  <= '0;
            count_q <= num_i;
        end else if (en_i) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign addr_o = addr_q;
    assign last_o = ({1'b0, addr_q} == count_q - 1'b1);

endmodule

// File: source/match_fsm.sv
`timescale 1ns/1ps

module match_fsm (
    input  logic clk,
    input  logic rst_i,
    input  logic start_i,
    input  logic last_i,
    output logic cnt_clear_o,
    output logic cnt_en_o,
    output logic acc_clear_o,
    output logic busy_o,
    output logic done_o
);

    // One cycle for the RAM read, one for the SAD register
    localparam logic [1:0] DRAIN_CYCLES = 2'd2;

    match_pkg::scan_state_e state_q;
    match_pkg::scan_state_e state_d;
    logic [1:0]             drain_q;
    logic                   launch;

    assign launch = (state_q == match_pkg::IDLE) && start_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            match_pkg::IDLE: begin
                if (start_i) begin
                    state_d = match_pkg::SCAN;
                end
            end
            match_pkg::SCAN: begin
                if (last_i) begin
                    state_d = match_pkg::DRAIN;
                end
            end
            match_pkg::DRAIN: begin
                if (drain_q == DRAIN_CYCLES - 1'b1) begin
                    state_d = match_pkg::DONE;
                end
            end
            match_pkg::DONE:  state_d = match_pkg::IDLE;
            default:          state_d = match_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= match_pkg::IDLE;
            drain_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == match_pkg::DRAIN) begin
                drain_q <= drain_q + 1'b1;
            end else begin
                drain_q <= '0;   // Ready for the next drain
            end
        end
    end

    assign cnt_clear_o = launch;
    assign acc_clear_o = launch;
    assign cnt_en_o    = (state_q == match_pkg::SCAN);
    assign busy_o      = (state_q != match_pkg::IDLE);
    assign done_o      = (state_q == match_pkg::DONE);

endmodule

// File: source/patch_sad.sv
`timescale 1ns/1ps

module patch_sad #(
    parameter int DATA_WIDTH = 11,
    parameter int PATCH_SIZE = 5
) (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              load_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]  cand_i,
    input  logic                              valid_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]  patch_i,
    output match_pkg::match_result_t          result_o
);

    localparam int PATCH_W = DATA_WIDTH * PATCH_SIZE;
    localparam int IDX_W   = match_pkg::IDX_W;
    localparam int SAD_W   = match_pkg::SAD_W;

    logic [PATCH_W-1:0]       cand_q;
    logic                     valid_d;    // Lines up with RAM read data
    logic [IDX_W-1:0]         idx_q;
    logic [DATA_WIDTH-1:0]    pix_c;
    logic [DATA_WIDTH-1:0]    pix_p;
    logic [DATA_WIDTH-1:0]    pix_diff;
    logic [SAD_W-1:0]         sad_sum;
    logic                     s1_valid;
    logic [SAD_W-1:0]         s1_sad;
    logic [IDX_W-1:0]         s1_idx;
    match_pkg::match_result_t best_q;

    always_ff @(posedge clk) begin
        if (load_i) begin
            cand_q <= cand_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_d <= 1'b0;
            idx_q   <= '0;
        end else begin
            valid_d <= valid_i;
            if (load_i) begin
                idx_q <= '0;
            end else if (valid_d) begin
                idx_q <= idx_q + 1'b1;   // Next entry out of the RAM
            end
        end
    end

    // Sum of absolute differences over all fields
    always_comb begin
        sad_sum  = '0;
        pix_c    = '0;
        pix_p    = '0;
        pix_diff = '0;
        for (int i = 0; i < PATCH_SIZE; i++) begin
            pix_c    = cand_q[i*DATA_WIDTH +: DATA_WIDTH];
            pix_p    = patch_i[i*DATA_WIDTH +: DATA_WIDTH];
            pix_diff = (pix_c > pix_p) ? pix_c - pix_p : pix_p - pix_c;
            sad_sum  = sad_sum + SAD_W'(pix_diff);
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_d & ~load_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_sad <= sad_sum;
        s1_idx <= idx_q;
    end

    // Stage 2, strict compare keeps the earlier index on a tie
    always_ff @(posedge clk) begin
        if (rst_i) begin
            best_q <= '0;
        end else if (load_i) begin
            best_q.best_idx <= '0;
            best_q.best_sad <= '1;
        end else if (s1_valid && (s1_sad < best_q.best_sad)) begin
            best_q.best_idx <= s1_idx;
            best_q.best_sad <= s1_sad;
        end
    end

    assign result_o = best_q;

endmodule

// File: source/match_top.sv
`timescale 1ns/1ps

module match_top #(
    parameter int DATA_WIDTH = 11,
    parameter int PATCH_SIZE = 5,
    parameter int ADDR_WIDTH = 9,
    parameter int DEPTH      = 512,
    parameter int HOST_BASE  = 557
) (
    input  logic                                 clk,
    input  logic                                 rst_i,
    // Host port
    input  logic                                 host_we_i,
    input  logic                                 host_re_i,
    input  logic [31:0]                          host_addr_i,
    input  match_pkg::host_cmd_u                 host_cmd_i,
    output logic [match_pkg::HOST_WORD_W-1:0]    host_rdata_o,
    // Scan port
    input  logic                                 start_i,
    input  logic [ADDR_WIDTH:0]                  num_i,
    input  logic [DATA_WIDTH*PATCH_SIZE-1:0]     cand_i,
    output logic                                 busy_o,
    output logic                                 done_o,
    output match_pkg::match_result_t             result_o
);

    logic                             cnt_clear;
    logic                             cnt_en;
    logic                             acc_clear;
    logic [ADDR_WIDTH-1:0]            scan_addr;
    logic                             last_addr;
    logic [DATA_WIDTH*PATCH_SIZE-1:0] eng_patch;

    query_patch_mem #(
        .DATA_WIDTH   (DATA_WIDTH),
        .PATCH_SIZE   (PATCH_SIZE),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .DEPTH        (DEPTH),
        .HOST_BASE    (HOST_BASE)
    ) u_mem (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_we_i    (host_we_i),
        .host_re_i    (host_re_i),
        .host_addr_i  (host_addr_i),
        .host_cmd_i   (host_cmd_i),
        .host_rdata_o (host_rdata_o),
        .eng_re_i     (cnt_en),       // Read one entry per scan cycle
        .eng_addr_i   (scan_addr),
        .eng_patch_o  (eng_patch)
    );

    scan_counter #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_counter (
        .clk        (clk),
        .rst_i      (rst_i),
        .clear_i    (cnt_clear),
        .en_i       (cnt_en),
        .num_i      (num_i),
        .addr_o     (scan_addr),
        .last_o     (last_addr)
    );

    match_fsm u_fsm (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .last_i      (last_addr),
        .cnt_clear_o (cnt_clear),
        .cnt_en_o    (cnt_en),
        .acc_clear_o (acc_clear),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    patch_sad #(
        .DATA_WIDTH (DATA_WIDTH),
        .PATCH_SIZE (PATCH_SIZE)
    ) u_sad (
        .clk        (clk),
        .rst_i      (rst_i),
        .load_i     (acc_clear),
        .cand_i     (cand_i),
        .valid_i    (cnt_en),
        .patch_i    (eng_patch),
        .result_o   (result_o)
    );

endmodule

// File: bench/match_tb.sv
`timescale 1ns/1ps

module match_tb;

    localparam int DATA_WIDTH = 11;
    localparam int PATCH_SIZE = 5;
    localparam int ADDR_WIDTH = 9;
    localparam int DEPTH      = 512;
    localparam int HOST_BASE  = 557;
    localparam int PATCH_W    = DATA_WIDTH * PATCH_SIZE;
    localparam int N_ENTRIES  = 16;

    typedef struct packed {
        logic [ADDR_WIDTH:0]      num;
        logic                     exact;     // Candidate copied from entry k
        logic [3:0]               k;
        logic                     poke;      // Single lane write into entry k first
        logic                     restart;   // Extra start pulse in the middle of the scan
        logic [PATCH_W-1:0]       cand;
        match_pkg::match_result_t exp_res;
    } scan_case_t;

    logic                              clk;
    logic                              rst_i;
    logic                              host_we_i;
    logic                              host_re_i;
    logic [31:0]                       host_addr_i;
    match_pkg::host_cmd_u              host_cmd_i;
    logic [match_pkg::HOST_WORD_W-1:0] host_rdata_o;
    logic                              start_i;
    logic [ADDR_WIDTH:0]               num_i;
    logic [PATCH_W-1:0]                cand_i;
    logic                              busy_o;
    logic                              done_o;
    match_pkg::match_result_t          result_o;

    logic [PATCH_W-1:0] patches [N_ENTRIES];   // Model of the stored table
    scan_case_t         cases[$];
    integer             seed;
    int                 timeout_ns;
    logic               table_ready;

    match_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .PATCH_SIZE (PATCH_SIZE),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DEPTH      (DEPTH),
        .HOST_BASE  (HOST_BASE)
    ) dut0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_we_i    (host_we_i),
        .host_re_i    (host_re_i),
        .host_addr_i  (host_addr_i),
        .host_cmd_i   (host_cmd_i),
        .host_rdata_o (host_rdata_o),
        .start_i      (start_i),
        .num_i        (num_i),
        .cand_i       (cand_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .result_o     (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #(timeout_ns);
        $display("Watchdog expired after %0d ns before the tests finished", timeout_ns);
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic ensure(input logic cond, input string what);
        if (cond !== 1'b1) begin
            $display("%s", what);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [match_pkg::HOST_WORD_W-1:0] got,
                              input logic [match_pkg::HOST_WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_result(input string name, input match_pkg::match_result_t got,
                                input match_pkg::match_result_t exp);
        if (got !== exp) begin
            $display("FAIL %s got idx 0x%h sad 0x%h expected idx 0x%h sad 0x%h", name,
                     got.best_idx, got.best_sad, exp.best_idx, exp.best_sad);
            report_failure();
        end
    endtask

    function automatic logic [match_pkg::SAD_W-1:0] sad_of(input logic [PATCH_W-1:0] a,
                                                           input logic [PATCH_W-1:0] b);
        int total;
        int pa;
        int pb;
        total = 0;
        for (int i = 0; i < PATCH_SIZE; i++) begin
            pa = int'(a[i*DATA_WIDTH +: DATA_WIDTH]);
            pb = int'(b[i*DATA_WIDTH +: DATA_WIDTH]);
            total += (pa > pb) ? pa - pb : pb - pa;
        end
        return match_pkg::SAD_W'(total);
    endfunction

    function automatic match_pkg::match_result_t best_match(input logic [PATCH_W-1:0] cand,
                                                           input int num);
        match_pkg::match_result_t    res;
        logic [match_pkg::SAD_W-1:0] s;
        res.best_idx = '0;
        res.best_sad = '1;
        for (int i = 0; i < num; i++) begin
            s = sad_of(cand, patches[i]);
            if (s < res.best_sad) begin   // Strictly lower keeps the first index on a tie
                res.best_idx = match_pkg::IDX_W'(i);
                res.best_sad = s;
            end
        end
        return res;
    endfunction

    task automatic write_lane(input int idx, input int lane, input logic [7:0] data);
        host_we_i = 1'b1;
        host_addr_i = 32'(HOST_BASE + idx);
        host_cmd_i = '0;
        host_cmd_i.wr_cmd.lane = 3'(lane);
        host_cmd_i.wr_cmd.data = data;
        @(posedge clk);
        #1;
        host_we_i = 1'b0;
    endtask

    task automatic read_half(input int idx, input logic half, output logic [31:0] data);
        host_re_i = 1'b1;
        host_addr_i = 32'(HOST_BASE + idx);
        host_cmd_i = '0;
        host_cmd_i.rd_cmd.half = half;
        @(posedge clk);
        #1;
        host_re_i = 1'b0;
        host_cmd_i.rd_cmd.half = ~half;   // Returned half must follow the strobe cycle
        data = host_rdata_o;
    endtask

    task automatic load_entry(input int idx);
        logic [63:0] word;
        word = {$random(seed), $random(seed)};   // Junk above the patch that readback ignores
        word[PATCH_W-1:0] = patches[idx];
        for (int l = 0; l < match_pkg::RAM_LANES; l++) begin
            write_lane(idx, l, word[l*8 +: 8]);
        end
    endtask

    task automatic check_entry(input int idx);
        logic [63:0] word;
        logic [31:0] data;
        word = 64'(patches[idx]);
        read_half(idx, 1'b0, data);
        check_word("host_rdata_o half 0", data, word[31:0]);
        read_half(idx, 1'b1, data);
        check_word("host_rdata_o half 1", data, word[63:32]);
    endtask

    task automatic add_case(input int num, input logic exact, input int k, input logic poke,
                            input logic restart);
        scan_case_t c;
        c = '0;
        c.num = num[ADDR_WIDTH:0];
        c.exact = exact;
        c.k = k[3:0];
        c.poke = poke;
        c.restart = restart;
        c.cand = PATCH_W'({$random(seed), $random(seed)});
        cases.push_back(c);
        timeout_ns += (num + 10) * 10;
    endtask

    task automatic run_scan(input scan_case_t c);
        int cycles;
        num_i = c.num;
        cand_i = c.cand;
        start_i = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            start_i = c.restart && (cycles == 2);
            if (start_i) begin
                num_i = 1;
                cand_i = ~c.cand;
            end
            ensure(busy_o, "busy_o is low while a scan is running");
            ensure(cycles <= c.num + 3, "done_o did not rise within num_i + 3 cycles");
        end while (done_o !== 1'b1);
        ensure(cycles == c.num + 3, $sformatf("done_o rose %0d cycles after start, not %0d",
                                              cycles, c.num + 3));
        check_result("result_o", result_o, c.exp_res);
        @(posedge clk);
        #1;
        ensure(done_o == 1'b0, "done_o stayed high for more than one cycle");
        check_result("result_o held after done", result_o, c.exp_res);
    endtask

    initial begin
        scan_case_t c;
        logic [7:0] new_byte;
        seed = 32'hdf443a8b;
        table_ready = 1'b0;
        timeout_ns = (N_ENTRIES * (match_pkg::RAM_LANES + 4) + 40) * 10;   // Reset, load and readback
        rst_i = 1'b1;
        host_we_i = 1'b0;
        host_re_i = 1'b0;
        host_addr_i = '0;
        host_cmd_i = '0;
        start_i = 1'b0;
        num_i = '0;
        cand_i = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            patches[i] = PATCH_W'({$random(seed), $random(seed)});
        end
        patches[15] = patches[2];   // Twin entries for the tie case
        add_case(16, 1'b1, 5, 1'b0, 1'b0);
        add_case(8, 1'b1, 7, 1'b0, 1'b0);
        add_case(16, 1'b1, 2, 1'b0, 1'b0);
        add_case(16, 1'b0, 0, 1'b0, 1'b0);
        add_case(10, 1'b0, 0, 1'b0, 1'b0);
        add_case(1, 1'b0, 0, 1'b0, 1'b0);
        add_case(12, 1'b0, 0, 1'b0, 1'b1);
        add_case(16, 1'b1, 4, 1'b1, 1'b0);
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;
        ensure(busy_o == 1'b0 && done_o == 1'b0, "busy_o or done_o is high after reset");
        check_result("result_o after reset", result_o, '0);
        check_word("host_rdata_o after reset", host_rdata_o, '0);
        for (int i = 0; i < N_ENTRIES; i++) begin
            load_entry(i);
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            check_entry(i);
        end
        foreach (cases[i]) begin
            c = cases[i];
            if (c.poke) begin
                new_byte = ~patches[c.k][23:16];
                write_lane(c.k, 2, new_byte);
                patches[c.k][23:16] = new_byte;
                check_entry(c.k);
            end
            if (c.exact) begin
                c.cand = patches[c.k];
            end
            c.exp_res = best_match(c.cand, c.num);
            run_scan(c);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: build.f
source/match_pkg.sv
source/patch_ram.sv
source/query_patch_mem.sv
source/scan_counter.sv
source/match_fsm.sv
source/patch_sad.sv
source/match_top.sv
bench/match_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the patch matcher testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f build.f --top-module match_tb -o match_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/match_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
